// File: mandel_pkg.sv
// Mandelbrot image types: fixed-point values, pixels, colours and the band palette
package mandel_pkg;

	// Q4.23 signed fixed point
	localparam int FRAC_BITS = 23;
	typedef logic signed [26:0] fix_t;

	typedef logic [9:0] iter_t;

	// RGB 3-3-2
	typedef logic [7:0] color_t;

	////////////////////////////////////////////////////////////
	// Image geometry
	////////////////////////////////////////////////////////////

	localparam int IMG_W = 16;
	localparam int IMG_H = 8;
	localparam int PIX_ADDR_W = $clog2(IMG_W * IMG_H);

	// Row-major pixel index
	typedef logic [PIX_ADDR_W-1:0] pix_addr_t;

	// One write into the frame memory
	typedef struct packed {
		pix_addr_t addr;
		color_t    color;
	} pix_wr_t;

	// Band 0 is inside the set, higher bands escape sooner
	localparam color_t PALETTE [10] = '{
		8'b000_000_00,
		8'b111_111_11,
		8'b111_110_01,
		8'b111_100_00,
		8'b101_010_01,
		8'b011_001_01,
		8'b001_001_10,
		8'b011_010_10,
		8'b010_100_10,
		8'b001_011_11
	};

endpackage

// File: axil_pkg.sv
// AXI4-Lite channel structs and the renderer register map
package axil_pkg;

	typedef logic [15:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;

	// Host to slave
	typedef struct packed {
		logic       aw_valid;
		axil_addr_t aw_addr;
		logic       w_valid;
		axil_data_t w_data;
		logic [3:0] w_strb;
		logic       b_ready;
		logic       ar_valid;
		axil_addr_t ar_addr;
		logic       r_ready;
	} axil_req_t;

	// Slave to host
	typedef struct packed {
		logic       aw_ready;
		logic       w_ready;
		logic       b_valid;
		logic [1:0] b_resp;
		logic       ar_ready;
		logic       r_valid;
		axil_data_t r_data;
		logic [1:0] r_resp;
	} axil_rsp_t;

	localparam logic [1:0] RESP_OKAY = 2'b00;

	// Register offsets
	localparam axil_addr_t REG_CTRL     = 16'h0000;
	localparam axil_addr_t REG_STATUS   = 16'h0004;
	localparam axil_addr_t REG_CR_START = 16'h0008;
	localparam axil_addr_t REG_CI_START = 16'h000C;
	localparam axil_addr_t REG_DX       = 16'h0010;
	localparam axil_addr_t REG_DY       = 16'h0014;
	localparam axil_addr_t REG_MAX_ITER = 16'h0018;

	// Pixel p lives at FRAME_BASE + 4*p
	localparam axil_addr_t FRAME_BASE   = 16'h1000;

endpackage

// File: escape_iterator.sv
// Escape-time iteration of one point c in Q4.23, one step per cycle
module escape_iterator import mandel_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  start,
	input  fix_t  cr,
	input  fix_t  ci,
	input  iter_t max_iter,
	output logic  done,
	output iter_t count
);

	typedef enum logic {IDLE, CALC} state_t;

	// Escape limits: 2.0 per component, 4.0 on the squared radius
	localparam fix_t TWO = fix_t'(2 << FRAC_BITS);
	localparam logic signed [27:0] FOUR = 28'(4 << FRAC_BITS);

	state_t state_q;
	iter_t  iter_q;
	logic   done_q;
	fix_t   zr_q;
	fix_t   zi_q;
	fix_t   zr_sq_q;
	fix_t   zi_sq_q;

	fix_t   zr_next;
	fix_t   zi_next;
	fix_t   zr_sq_next;
	fix_t   zi_sq_next;
	logic signed [27:0] mag_sq;
	iter_t  step;
	logic   escaped;
	logic   finish;

	// Full-width product, back to Q4.23
	function automatic fix_t fix_mul(fix_t a, fix_t b);
		logic signed [53:0] p;
		p = a * b;
		return p[FRAC_BITS +: 27];
	endfunction

	////////////////////////////////////////////////////////////
	// One step: z = z^2 + c, then squares of the new z
	////////////////////////////////////////////////////////////

	always_comb begin
		zr_next    = zr_sq_q - zi_sq_q + cr;
		zi_next    = (fix_mul(zr_q, zi_q) <<< 1) + ci;
		zr_sq_next = fix_mul(zr_next, zr_next);
		zi_sq_next = fix_mul(zi_next, zi_next);
		// Squares only matter once both parts are below 2, so no overflow here
		mag_sq     = 28'(zr_sq_next) + 28'(zi_sq_next);
		escaped    = zr_next >= TWO || zr_next <= -TWO || zi_next >= TWO || zi_next <= -TWO
			|| mag_sq > FOUR;
		step       = iter_q + 1'b1;
		finish     = escaped || step >= max_iter;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= IDLE;
			iter_q  <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				IDLE: begin
					if (start) begin
						iter_q  <= '0;
						state_q <= CALC;
					end
				end
				CALC: begin
					iter_q <= step;
					if (finish) begin
						done_q  <= 1'b1;
						state_q <= IDLE;
					end
				end
			endcase
		end
	end

	// z restarts at zero while idle
	always_ff @(posedge clk) begin
		if (state_q == IDLE) begin
			zr_q    <= '0;
			zi_q    <= '0;
			zr_sq_q <= '0;
			zi_sq_q <= '0;
		end else begin
			zr_q    <= zr_next;
			zi_q    <= zi_next;
			zr_sq_q <= zr_sq_next;
			zi_sq_q <= zi_sq_next;
		end
	end

	assign done  = done_q;
	assign count = iter_q;

endmodule

// File: pixel_engine.sv
// Pixel engine: renders every N_ENGINES-th column and queues colours for the frame memory
module pixel_engine import mandel_pkg::*; #(
	parameter int N_ENGINES = 4,
	parameter int ENGINE_ID = 0
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  fix_t    cr_start,
	input  fix_t    ci_start,
	input  fix_t    dx,
	input  fix_t    dy,
	input  iter_t   max_iter,
	input  logic    wr_grant,
	output pix_wr_t wr_req,
	output logic    wr_valid,
	output logic    done
);

	localparam int XW = $clog2(IMG_W + N_ENGINES);
	localparam int YW = $clog2(IMG_H + 1);

	typedef enum logic [1:0] {IDLE, ITERATE, WRITE, DONE} state_t;

	state_t        state_q;
	logic          it_start_q;
	logic [XW-1:0] x_q;
	logic [YW-1:0] y_q;
	fix_t          cr_q;
	fix_t          ci_q;
	fix_t          cr_row_q;
	fix_t          dx_step_q;
	fix_t          dy_q;
	iter_t         max_iter_q;

	logic          take_start;
	fix_t          cr_first;
	logic [XW-1:0] x_next;
	logic          row_end;
	logic          last_pix;
	logic          it_done;
	iter_t         it_count;

	// Smallest band s with count >= max_iter >> s, band 0 for the set itself
	function automatic color_t band_color(iter_t cnt, iter_t lim);
		int band;
		band = 9;
		if (cnt >= lim) begin
			band = 0;
		end else begin
			for (int s = 8; s >= 1; s--) begin
				if (cnt >= (lim >> s)) begin
					band = s;
				end
			end
		end
		return PALETTE[band];
	endfunction

	assign take_start = (state_q == IDLE || state_q == DONE) && start;
	assign cr_first   = cr_start + fix_t'(ENGINE_ID * dx);
	assign x_next     = x_q + XW'(N_ENGINES);
	assign row_end    = x_next >= XW'(IMG_W);
	assign last_pix   = row_end && y_q == YW'(IMG_H - 1);

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q    <= IDLE;
			it_start_q <= 1'b0;
		end else begin
			it_start_q <= 1'b0;
			case (state_q)
				IDLE, DONE: begin
					if (start) begin
						// Engines past the image width own no columns
						if (ENGINE_ID < IMG_W) begin
							state_q    <= ITERATE;
							it_start_q <= 1'b1;
						end else begin
							state_q <= DONE;
						end
					end
				end
				ITERATE: begin
					if (it_done) begin
						state_q <= WRITE;
					end
				end
				WRITE: begin
					if (wr_grant) begin
						if (last_pix) begin
							state_q <= DONE;
						end else begin
							state_q    <= ITERATE;
							it_start_q <= 1'b1;
						end
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Pixel walk and write request
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (take_start) begin
			cr_row_q   <= cr_first;
			cr_q       <= cr_first;
			ci_q       <= ci_start;
			dx_step_q  <= fix_t'(N_ENGINES * dx);
			dy_q       <= dy;
			max_iter_q <= max_iter;
			x_q        <= XW'(ENGINE_ID);
			y_q        <= '0;
		end else if (state_q == ITERATE && it_done) begin
			wr_req.addr  <= pix_addr_t'(y_q * IMG_W + x_q);
			wr_req.color <= band_color(it_count, max_iter_q);
		end else if (state_q == WRITE && wr_grant) begin
			if (row_end) begin
				x_q  <= XW'(ENGINE_ID);
				y_q  <= y_q + 1'b1;
				cr_q <= cr_row_q;
				ci_q <= ci_q - dy_q;
			end else begin
				x_q  <= x_next;
				cr_q <= cr_q + dx_step_q;
			end
		end
	end

	escape_iterator iter_i (
		.clk      (clk),
		.rst      (rst),
		.start    (it_start_q),
		.cr       (cr_q),
		.ci       (ci_q),
		.max_iter (max_iter_q),
		.done     (it_done),
		.count    (it_count)
	);

	assign wr_valid = state_q == WRITE;
	assign done     = state_q == DONE;

endmodule

// File: frame_store.sv
// Frame memory with a round-robin write arbiter over the engines and a host read port
module frame_store import mandel_pkg::*; #(
	parameter int N_ENGINES = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	input  pix_wr_t [N_ENGINES-1:0] wr_req,
	input  logic [N_ENGINES-1:0]    wr_valid,
	input  pix_addr_t               rd_addr,
	output logic [N_ENGINES-1:0]    wr_grant,
	output color_t                  rd_color
);

	localparam int IW = (N_ENGINES > 1) ? $clog2(N_ENGINES) : 1;

	color_t        mem [IMG_W * IMG_H];
	logic [IW-1:0] last_q;
	logic [IW-1:0] sel;
	logic          any_grant;

	// Search starts one past the engine granted last
	always_comb begin
		int idx;
		wr_grant  = '0;
		sel       = last_q;
		any_grant = 1'b0;
		for (int i = 1; i <= N_ENGINES; i++) begin
			idx = int'(last_q) + i;
			if (idx >= N_ENGINES) begin
				idx = idx - N_ENGINES;
			end
			if (!any_grant && wr_valid[idx]) begin
				any_grant     = 1'b1;
				sel           = IW'(idx);
				wr_grant[idx] = 1'b1;
			end
		end
	end

	// Engine 0 wins first after reset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			last_q <= IW'(N_ENGINES - 1);
		end else if (any_grant) begin
			last_q <= sel;
		end
	end

	always_ff @(posedge clk) begin
		if (any_grant) begin
			mem[wr_req[sel].addr] <= wr_req[sel].color;
		end
		rd_color <= mem[rd_addr];
	end

endmodule

// File: axil_regs.sv
// AXI4-Lite register slave: view setup, frame start and status, pixel read-back
module axil_regs import mandel_pkg::*, axil_pkg::*; #(
	parameter int N_ENGINES = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  axil_req_t            axil_req,
	output axil_rsp_t            axil_rsp,
	input  logic [N_ENGINES-1:0] engine_done,
	input  color_t               rd_color,
	output logic                 start,
	output fix_t                 cr_start,
	output fix_t                 ci_start,
	output fix_t                 dx,
	output fix_t                 dy,
	output iter_t                max_iter,
	output pix_addr_t            rd_addr
);

	localparam int FRAME_BYTES = 4 * IMG_W * IMG_H;

	logic       wr_fire;
	logic       start_ok;
	logic       b_valid_q;
	logic       start_q;
	logic       busy_q;
	logic       done_q;
	logic       rd_fire;
	logic       ar_in_frame;
	logic       frame_pend_q;
	logic       r_valid_q;
	axil_data_t r_data_q;
	axil_data_t reg_rdata;
	axil_addr_t frame_off;

	// Byte lanes with a set strobe take the new data
	function automatic axil_data_t merge_bytes(axil_data_t old, axil_data_t wdata,
			logic [3:0] strb);
		axil_data_t res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// Write channel
	////////////////////////////////////////////////////////////

	// AW and W are taken together, only with no B pending
	assign wr_fire = axil_req.aw_valid && axil_req.w_valid && !b_valid_q;

	assign start_ok = wr_fire && axil_req.aw_addr == REG_CTRL && axil_req.w_strb[0]
		&& axil_req.w_data[0] && !busy_q && !start_q && max_iter != '0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cr_start <= '0;
			ci_start <= '0;
			dx       <= '0;
			dy       <= '0;
			max_iter <= '0;
		end else if (wr_fire) begin
			case (axil_req.aw_addr)
				REG_CR_START: cr_start <= fix_t'(merge_bytes(axil_data_t'(cr_start),
					axil_req.w_data, axil_req.w_strb));
				REG_CI_START: ci_start <= fix_t'(merge_bytes(axil_data_t'(ci_start),
					axil_req.w_data, axil_req.w_strb));
				REG_DX: dx <= fix_t'(merge_bytes(axil_data_t'(dx),
					axil_req.w_data, axil_req.w_strb));
				REG_DY: dy <= fix_t'(merge_bytes(axil_data_t'(dy),
					axil_req.w_data, axil_req.w_strb));
				REG_MAX_ITER: max_iter <= iter_t'(merge_bytes(axil_data_t'(max_iter),
					axil_req.w_data, axil_req.w_strb));
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			b_valid_q <= 1'b0;
		end else if (wr_fire) begin
			b_valid_q <= 1'b1;
		end else if (axil_req.b_ready) begin
			b_valid_q <= 1'b0;
		end
	end

	// Busy spans from the cycle after start until all engines report done
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			start_q <= 1'b0;
			busy_q  <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			start_q <= start_ok;
			if (start_q) begin
				busy_q <= 1'b1;
				done_q <= 1'b0;
			end else if (busy_q && &engine_done) begin
				busy_q <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	assign start = start_q;

	////////////////////////////////////////////////////////////
	// Read channel
	////////////////////////////////////////////////////////////

	assign rd_fire     = axil_req.ar_valid && !r_valid_q && !frame_pend_q;
	assign ar_in_frame = axil_req.ar_addr >= FRAME_BASE
		&& axil_req.ar_addr < FRAME_BASE + FRAME_BYTES;

	// Memory sees the address in the AR cycle, colour comes back next cycle
	assign frame_off = axil_req.ar_addr - FRAME_BASE;
	assign rd_addr   = frame_off[2 +: PIX_ADDR_W];

	always_comb begin
		case (axil_req.ar_addr)
			REG_STATUS:   reg_rdata = {30'b0, done_q, busy_q};
			REG_CR_START: reg_rdata = axil_data_t'(cr_start);
			REG_CI_START: reg_rdata = axil_data_t'(ci_start);
			REG_DX:       reg_rdata = axil_data_t'(dx);
			REG_DY:       reg_rdata = axil_data_t'(dy);
			REG_MAX_ITER: reg_rdata = axil_data_t'(max_iter);
			default:      reg_rdata = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			frame_pend_q <= 1'b0;
			r_valid_q    <= 1'b0;
		end else begin
			frame_pend_q <= rd_fire && ar_in_frame;
			if (frame_pend_q || (rd_fire && !ar_in_frame)) begin
				r_valid_q <= 1'b1;
			end else if (axil_req.r_ready) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	// Held until R ready
	always_ff @(posedge clk) begin
		if (frame_pend_q) begin
			r_data_q <= axil_data_t'(rd_color);
		end else if (rd_fire) begin
			r_data_q <= reg_rdata;
		end
	end

	always_comb begin
		axil_rsp          = '0;
		axil_rsp.aw_ready = wr_fire;
		axil_rsp.w_ready  = wr_fire;
		axil_rsp.b_valid  = b_valid_q;
		axil_rsp.b_resp   = RESP_OKAY;
		axil_rsp.ar_ready = !r_valid_q && !frame_pend_q;
		axil_rsp.r_valid  = r_valid_q;
		axil_rsp.r_data   = r_data_q;
		axil_rsp.r_resp   = RESP_OKAY;
	end

endmodule

// File: mandel_top.sv
// Mandelbrot renderer top: AXI4-Lite registers, parallel pixel engines, shared frame memory
module mandel_top import mandel_pkg::*, axil_pkg::*; #(
	parameter int N_ENGINES = 4
) (
	input  logic      clk,
	input  logic      rst,
	input  axil_req_t axil_req,
	output axil_rsp_t axil_rsp
);

	logic                    start;
	fix_t                    cr_start;
	fix_t                    ci_start;
	fix_t                    dx;
	fix_t                    dy;
	iter_t                   max_iter;
	logic [N_ENGINES-1:0]    engine_done;
	pix_wr_t [N_ENGINES-1:0] wr_req;
	logic [N_ENGINES-1:0]    wr_valid;
	logic [N_ENGINES-1:0]    wr_grant;
	pix_addr_t               rd_addr;
	color_t                  rd_color;

	axil_regs #(.N_ENGINES(N_ENGINES)) axil_regs_i (
		.clk         (clk),
		.rst         (rst),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp),
		.engine_done (engine_done),
		.rd_color    (rd_color),
		.start       (start),
		.cr_start    (cr_start),
		.ci_start    (ci_start),
		.dx          (dx),
		.dy          (dy),
		.max_iter    (max_iter),
		.rd_addr     (rd_addr)
	);

	// Engine i owns the columns x with x mod N_ENGINES == i
	for (genvar i = 0; i < N_ENGINES; i++) begin : gen_engine
		pixel_engine #(.N_ENGINES(N_ENGINES), .ENGINE_ID(i)) pixel_engine_i (
			.clk      (clk),
			.rst      (rst),
			.start    (start),
			.cr_start (cr_start),
			.ci_start (ci_start),
			.dx       (dx),
			.dy       (dy),
			.max_iter (max_iter),
			.wr_grant (wr_grant[i]),
			.wr_req   (wr_req[i]),
			.wr_valid (wr_valid[i]),
			.done     (engine_done[i])
		);
	end

	frame_store #(.N_ENGINES(N_ENGINES)) frame_store_i (
		.clk      (clk),
		.rst      (rst),
		.wr_req   (wr_req),
		.wr_valid (wr_valid),
		.rd_addr  (rd_addr),
		.wr_grant (wr_grant),
		.rd_color (rd_color)
	);

endmodule

// File: tb_mandel_ref.svh
// Reference model of the Mandelbrot renderer: fixed-point escape iteration and palette banding
`ifndef TB_MANDEL_REF_SVH
`define TB_MANDEL_REF_SVH

	// Default view, kept inside |c| < 2
	localparam fix_t  DEF_CR       = fix_t'(-(3 << 22));
	localparam fix_t  DEF_CI       = fix_t'(1 << 23);
	localparam fix_t  DEF_DX       = fix_t'(1 << 20);
	localparam fix_t  DEF_DY       = fix_t'(1 << 21);
	localparam iter_t DEF_MAX_ITER = iter_t'(40);

	// Escape thresholds in Q4.23
	localparam longint LIM_TWO  = longint'(2) << FRAC_BITS;
	localparam longint LIM_FOUR = longint'(4) << FRAC_BITS;

	// Full-width product, shifted back to Q4.23 and wrapped to 27 bits
	function automatic fix_t fixed_mul(fix_t a, fix_t b);
		longint p;
		p = longint'(a) * longint'(b);
		return fix_t'(p >>> FRAC_BITS);
	endfunction

	function automatic int escape_count(fix_t cr, fix_t ci, int limit);
		fix_t   zr;
		fix_t   zi;
		fix_t   nr;
		fix_t   ni;
		longint radius;
		int     k;
		int     cnt;
		bit     out;
		zr  = '0;
		zi  = '0;
		k   = 0;
		cnt = limit;
		out = 1'b0;
		while (!out && k < limit) begin
			k++;
			nr = fixed_mul(zr, zr) - fixed_mul(zi, zi) + cr;
			ni = fix_t'(2 * fixed_mul(zr, zi)) + ci;
			radius = longint'(fixed_mul(nr, nr)) + longint'(fixed_mul(ni, ni));
			if (longint'(nr) >= LIM_TWO || longint'(nr) <= -LIM_TWO
					|| longint'(ni) >= LIM_TWO || longint'(ni) <= -LIM_TWO
					|| radius > LIM_FOUR) begin
				cnt = k;
				out = 1'b1;
			end
			zr = nr;
			zi = ni;
		end
		return cnt;
	endfunction

	// Expected colour of pixel (x, y) for a given view
	function automatic color_t pixel_color(int x, int y, fix_t cr0, fix_t ci0,
			fix_t dx, fix_t dy, iter_t limit);
		fix_t cr;
		fix_t ci;
		int   cnt;
		int   band;
		cr   = fix_t'(longint'(cr0) + longint'(x) * longint'(dx));
		ci   = fix_t'(longint'(ci0) - longint'(y) * longint'(dy));
		cnt  = escape_count(cr, ci, int'(limit));
		band = 9;
		for (int s = 1; s <= 8; s++) begin
			if (band == 9 && cnt >= (int'(limit) >> s)) begin
				band = s;
			end
		end
		if (cnt >= int'(limit)) begin
			band = 0;
		end
		return PALETTE[band];
	endfunction

`endif

// File: tb_mandel.sv
// Testbench for the Mandelbrot renderer: AXI4-Lite access, frame checks against a reference model
module tb_mandel import mandel_pkg::*, axil_pkg::*; ();

	localparam int N_ENGINES       = 4;
	localparam int CLK_PERIOD      = 40;
	localparam int N_FRAMES        = 6;
	localparam int ITER_CEIL       = 64;
	localparam int WATCHDOG_CYCLES = N_FRAMES * IMG_W * IMG_H * (ITER_CEIL + 4) + 20000;

	logic      clk = 1'b0;
	logic      rst;
	axil_req_t req;
	axil_rsp_t rsp;

	int n_checks  = 0;
	int n_errors  = 0;
	int wr_open   = 0;
	int rd_open   = 0;
	int max_stall = 0;

	// View of the frame currently in memory
	fix_t  v_cr;
	fix_t  v_ci;
	fix_t  v_dx;
	fix_t  v_dy;
	iter_t v_max;

	// Outstanding reads, in issue order
	axil_data_t exp_q[$];
	axil_addr_t addr_q[$];
	bit         verify_q[$];

	`include "tb_mandel_ref.svh"

	mandel_top #(.N_ENGINES(N_ENGINES)) mandel_top_i (
		.clk      (clk),
		.rst      (rst),
		.axil_req (req),
		.axil_rsp (rsp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input axil_data_t got, input axil_data_t exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
		@(posedge clk);
		req.aw_valid <= 1'b1;
		req.aw_addr  <= addr;
		req.w_valid  <= 1'b1;
		req.w_data   <= data;
		req.w_strb   <= 4'hf;
		do @(posedge clk); while (!rsp.aw_ready);
		// W is taken in the same cycle as AW
		check_value("w_ready", 32'(rsp.w_ready), 32'h1);
		req.aw_valid <= 1'b0;
		req.w_valid  <= 1'b0;
		repeat ($urandom_range(max_stall, 0)) @(posedge clk);
		req.b_ready <= 1'b1;
		do @(posedge clk); while (!rsp.b_valid);
		check_value("b_resp", 32'(rsp.b_resp), 32'(RESP_OKAY));
		req.b_ready <= 1'b0;
	endtask

	// The response monitor does the comparison
	task automatic read_word(input axil_addr_t addr, input axil_data_t exp, input bit verify,
			output axil_data_t data);
		exp_q.push_back(exp);
		addr_q.push_back(addr);
		verify_q.push_back(verify);
		@(posedge clk);
		req.ar_valid <= 1'b1;
		req.ar_addr  <= addr;
		do @(posedge clk); while (!rsp.ar_ready);
		req.ar_valid <= 1'b0;
		repeat ($urandom_range(max_stall, 0)) @(posedge clk);
		req.r_ready <= 1'b1;
		do @(posedge clk); while (!rsp.r_valid);
		data = rsp.r_data;
		req.r_ready <= 1'b0;
	endtask

	always @(posedge clk) begin : rsp_monitor
		axil_data_t e;
		axil_addr_t a;
		bit         v;
		if (!rst) begin
			// A response with nothing outstanding is a duplicate
			if (rsp.b_valid && wr_open == 0) begin
				n_errors++;
				$display("ERROR: B valid with no write outstanding");
			end
			if (rsp.r_valid && rd_open == 0) begin
				n_errors++;
				$display("ERROR: R valid with no read outstanding");
			end
			if (req.aw_valid && rsp.aw_ready) begin
				wr_open++;
			end
			if (req.ar_valid && rsp.ar_ready) begin
				rd_open++;
			end
			if (rsp.b_valid && req.b_ready) begin
				wr_open--;
			end
			if (rsp.r_valid && req.r_ready) begin
				rd_open--;
				check_value("r_resp", 32'(rsp.r_resp), 32'(RESP_OKAY));
				if (exp_q.size() == 0) begin
					n_errors++;
					$display("ERROR: R response arrived with no read outstanding");
				end else begin
					e = exp_q.pop_front();
					a = addr_q.pop_front();
					v = verify_q.pop_front();
					if (v) begin
						check_value($sformatf("r_data[%h]", a), rsp.r_data, e);
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Frame tasks
	////////////////////////////////////////////////////////////

	task automatic set_view(input fix_t cr, input fix_t ci, input fix_t dx, input fix_t dy,
			input iter_t mi);
		v_cr  = cr;
		v_ci  = ci;
		v_dx  = dx;
		v_dy  = dy;
		v_max = mi;
		write_reg(REG_CR_START, 32'(cr));
		write_reg(REG_CI_START, 32'(ci));
		write_reg(REG_DX, 32'(dx));
		write_reg(REG_DY, 32'(dy));
		write_reg(REG_MAX_ITER, 32'(mi));
	endtask

	task automatic wait_frame();
		axil_data_t st;
		st = '0;
		while (!st[1]) begin
			read_word(REG_STATUS, '0, 1'b0, st);
		end
		check_value("status", st, 32'h2);
	endtask

	task automatic verify_frame();
		axil_data_t d;
		for (int p = 0; p < IMG_W * IMG_H; p++) begin
			read_word(FRAME_BASE + axil_addr_t'(4 * p),
				32'(pixel_color(p % IMG_W, p / IMG_W, v_cr, v_ci, v_dx, v_dy, v_max)),
				1'b1, d);
		end
	endtask

	initial begin : main
		fix_t       cr;
		fix_t       ci;
		fix_t       dx;
		fix_t       dy;
		iter_t      mi;
		axil_data_t st;
		void'($urandom(32'h75bb));
		req = '0;
		rst = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		// Idle status and register read-back
		read_word(REG_STATUS, '0, 1'b1, st);
		set_view(DEF_CR, DEF_CI, DEF_DX, DEF_DY, DEF_MAX_ITER);
		read_word(REG_CR_START, 32'(DEF_CR), 1'b1, st);
		read_word(REG_CI_START, 32'(DEF_CI), 1'b1, st);
		read_word(REG_DX, 32'(DEF_DX), 1'b1, st);
		read_word(REG_DY, 32'(DEF_DY), 1'b1, st);
		read_word(REG_MAX_ITER, 32'(DEF_MAX_ITER), 1'b1, st);
		read_word(16'h0040, '0, 1'b1, st);

		write_reg(REG_CTRL, 32'h1);
		wait_frame();
		verify_frame();

		// Random views with c inside cr [-1.5, 0) and ci [-0.875, 0.75]
		max_stall = 2;
		repeat (3) begin
			cr = fix_t'(-(3 << 22) + int'($urandom_range((1 << 22) - 1, 0)));
			ci = fix_t'($urandom_range(3 << 21, 0));
			dx = fix_t'($urandom_range(1 << 19, 1));
			dy = fix_t'($urandom_range(1 << 20, 1));
			mi = iter_t'($urandom_range(ITER_CEIL, 1));
			set_view(cr, ci, dx, dy, mi);
			write_reg(REG_CTRL, 32'h1);
			wait_frame();
			verify_frame();
		end
		max_stall = 0;

		// Second start while busy, engines keep the first view
		set_view(DEF_CR, DEF_CI, DEF_DX, DEF_DY, DEF_MAX_ITER);
		write_reg(REG_CTRL, 32'h1);
		read_word(REG_STATUS, '0, 1'b0, st);
		check_value("status.busy", 32'(st[0]), 32'h1);
		write_reg(REG_CR_START, 32'(DEF_CR + DEF_DX));
		write_reg(REG_CTRL, 32'h1);
		wait_frame();
		verify_frame();

		write_reg(REG_MAX_ITER, '0);
		write_reg(REG_CTRL, 32'h1);
		repeat (4) @(posedge clk);
		read_word(REG_STATUS, 32'h2, 1'b1, st);

		// Heavy back-pressure on B and R
		max_stall = 4;
		verify_frame();
		write_reg(REG_DX, 32'(DEF_DY));
		read_word(REG_DX, 32'(DEF_DY), 1'b1, st);
		repeat (3) @(posedge clk);

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("ERROR: timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: mandel.f
+incdir+.
mandel_pkg.sv
axil_pkg.sv
escape_iterator.sv
pixel_engine.sv
frame_store.sv
axil_regs.sv
mandel_top.sv
tb_mandel.sv

// File: run_sim.sh
#!/bin/sh
# Build and run tb_mandel with Verilator, then scan the log for the fail message
verilator --binary -Wno-fatal -f mandel.f --top-module tb_mandel -o tb_mandel \
	> build.log 2>&1 &&
./obj_dir/tb_mandel > sim.log 2>&1 ||
{ cat build.log; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
